// File: logic/bb_buf_pkg.sv
package bb_buf_pkg;

  ////////////////////////////////////////
  // payload words and buffer addresses.
  ////////////////////////////////////////

  typedef logic [31:0] word_t;
  typedef logic [7:0]  buf_addr_t; // word address inside one bank.
  typedef logic        chan_t;

  localparam chan_t CHAN_ACL = 1'b0;
  localparam chan_t CHAN_SCO = 1'b1;

  // host transmit write request.
  typedef struct packed {
    chan_t     chan;
    buf_addr_t addr;
    word_t     data;
  } host_wr_t;

  // host receive read request.
  typedef struct packed {
    chan_t     chan;
    buf_addr_t addr;
  } host_rd_t;

endpackage

// File: logic/bb_slot_pkg.sv
package bb_slot_pkg;

  ////////////////////////////////////////
  // slot timing.
  ////////////////////////////////////////

  typedef logic [12:0] bit_count_t; // payload bit count or index.

  // per-slot control from the link controller.
  typedef struct packed {
    logic       tslot_p;     // slot boundary.
    logic       lmp_cmd_p;   // lmp command request.
    logic       tx_reserved; // tx slot reserved for sco.
    logic       rx_reserved; // rx slot reserved for sco.
    bit_count_t tx_len;      // payload bits to send this slot.
  } slot_ctrl_t;

endpackage

// File: logic/slot_arbiter.sv
`timescale 1ns/1ps

module slot_arbiter (
  input  logic                   clk_6M,
  input  logic                   rstz,
  input  bb_slot_pkg::slot_ctrl_t slot_ctrl,
  output bb_buf_pkg::chan_t      tx_chan,
  output bb_buf_pkg::chan_t      rx_chan
);

  logic lmp_cmd;  // command waiting for a slot.
  logic lmp_slot; // current slot carries lmp.
  logic tx_res_q;
  logic rx_res_q;

  ////////////////////////////////////////
  // lmp command and slot flags.
  ////////////////////////////////////////

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      lmp_cmd <= 1'b0;
    else if (slot_ctrl.lmp_cmd_p)
      lmp_cmd <= 1'b1;
    else if (slot_ctrl.tslot_p)
      lmp_cmd <= 1'b0;
  end

  // reserved bits are sampled with the lmp flag at the boundary.
  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      lmp_slot <= 1'b0;
      tx_res_q <= 1'b0;
      rx_res_q <= 1'b0;
    end
    else if (slot_ctrl.tslot_p)
    begin
      lmp_slot <= lmp_cmd;
      tx_res_q <= slot_ctrl.tx_reserved;
      rx_res_q <= slot_ctrl.rx_reserved;
    end
  end

  ////////////////////////////////////////
  // channel select.
  ////////////////////////////////////////

  // an lmp slot always goes to acl.
  assign tx_chan = (tx_res_q && !lmp_slot) ? bb_buf_pkg::CHAN_SCO : bb_buf_pkg::CHAN_ACL;
  assign rx_chan = (rx_res_q && !lmp_slot) ? bb_buf_pkg::CHAN_SCO : bb_buf_pkg::CHAN_ACL;

endmodule

// File: logic/tx_payload_buffer.sv
`timescale 1ns/1ps

module tx_payload_buffer #(
  parameter int BANK_WORDS = 16
) (
  input  logic                  clk_6M,
  input  logic                  rstz,
  input  logic                  tx_seqn,
  input  logic                  tx_tsco_p,
  input  bb_buf_pkg::host_wr_t  host_wr,
  input  logic                  host_wr_valid,
  output logic                  host_wr_ready,
  input  bb_buf_pkg::chan_t     tx_chan,
  input  bb_buf_pkg::buf_addr_t fetch_addr,
  input  logic                  fetch_valid,
  output bb_buf_pkg::word_t     fetch_data,
  output logic                  fetch_data_valid
);

  localparam int AW = (BANK_WORDS > 1) ? $clog2(BANK_WORDS) : 1;

  // two banks per channel.
  bb_buf_pkg::word_t acl_ram [2][BANK_WORDS];
  bb_buf_pkg::word_t sco_ram [2][BANK_WORDS];

  logic          sco_bank;   // sco bank being transmitted.
  logic          host_bank;
  logic          fetch_bank;
  logic          host_we;
  logic          host_sco;
  logic          fetch_sco;
  logic [AW-1:0] host_idx;
  logic [AW-1:0] fetch_idx;

  ////////////////////////////////////////
  // bank steering.
  ////////////////////////////////////////

  assign host_sco  = (host_wr.chan == bb_buf_pkg::CHAN_SCO);
  assign fetch_sco = (tx_chan == bb_buf_pkg::CHAN_SCO);

  assign host_bank  = host_sco ? ~sco_bank : ~tx_seqn; // host fills the idle bank.
  assign fetch_bank = fetch_sco ? sco_bank : tx_seqn;

  assign host_idx  = host_wr.addr[AW-1:0];
  assign fetch_idx = fetch_addr[AW-1:0];

  // a fetch owns the ram of the transmitting channel.
  assign host_wr_ready = !(fetch_valid && (tx_chan == host_wr.chan));
  assign host_we       = host_wr_valid && host_wr_ready;

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      sco_bank         <= 1'b0;
      fetch_data_valid <= 1'b0;
    end
    else
    begin
      if (tx_tsco_p)
        sco_bank <= ~sco_bank;
      fetch_data_valid <= fetch_valid;
    end
  end

  ////////////////////////////////////////
  // rams.
  ////////////////////////////////////////

  always_ff @(posedge clk_6M)
  begin
    if (host_we && !host_sco)
      acl_ram[host_bank][host_idx] <= host_wr.data;
    if (host_we && host_sco)
      sco_ram[host_bank][host_idx] <= host_wr.data;
    if (fetch_valid)
    begin
      if (fetch_sco)
        fetch_data <= sco_ram[fetch_bank][fetch_idx];
      else
        fetch_data <= acl_ram[fetch_bank][fetch_idx];
    end
  end

endmodule

// File: logic/tx_bit_serializer.sv
`timescale 1ns/1ps

module tx_bit_serializer (
  input  logic                   clk_6M,
  input  logic                   rstz,
  input  logic                   tslot_p,
  input  bb_slot_pkg::bit_count_t tx_len,
  output bb_buf_pkg::buf_addr_t  fetch_addr,
  output logic                   fetch_valid,
  input  bb_buf_pkg::word_t      fetch_data,
  input  logic                   fetch_data_valid,
  output logic                   tx_bit,
  output logic                   tx_bit_valid,
  input  logic                   tx_bit_ready
);

  bb_slot_pkg::bit_count_t len;
  bb_slot_pkg::bit_count_t bit_idx;

  logic busy;
  logic have_word;  // fetch_data holds the current word.
  logic fetch_pend; // fetch issued, word not back yet.
  logic word_ok;
  logic accept;

  assign busy    = (bit_idx < len);
  assign word_ok = have_word || fetch_data_valid;
  assign accept  = tx_bit_valid && tx_bit_ready;

  // the boundary cycle never fetches, tx_chan is not settled yet.
  assign fetch_valid = busy && !have_word && !fetch_pend && !tslot_p;
  assign fetch_addr  = bit_idx[12:5];

  assign tx_bit_valid = busy && word_ok;
  assign tx_bit       = fetch_data[bit_idx[4:0]]; // lsb first.

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      len        <= '0;
      bit_idx    <= '0;
      have_word  <= 1'b0;
      fetch_pend <= 1'b0;
    end
    else if (tslot_p)
    begin
      len        <= tx_len;
      bit_idx    <= '0;
      have_word  <= 1'b0;
      fetch_pend <= 1'b0;
    end
    else
    begin
      if (fetch_valid)
        fetch_pend <= 1'b1;
      if (fetch_data_valid)
      begin
        fetch_pend <= 1'b0;
        have_word  <= 1'b1;
      end
      if (accept)
      begin
        bit_idx <= bit_idx + bb_slot_pkg::bit_count_t'(1);
        if (bit_idx[4:0] == 5'd31)
          have_word <= 1'b0; // word used up.
      end
    end
  end

endmodule

// File: logic/rx_bit_packer.sv
`timescale 1ns/1ps

module rx_bit_packer (
  input  logic                  clk_6M,
  input  logic                  rstz,
  input  logic                  tslot_p,
  input  logic                  rx_bit,
  input  logic                  rx_bit_valid,
  output logic                  rx_bit_ready,
  output bb_buf_pkg::buf_addr_t wr_addr,
  output bb_buf_pkg::word_t     wr_data,
  output logic                  wr_valid,
  input  logic                  wr_ready
);

  bb_buf_pkg::word_t     sreg;
  bb_buf_pkg::buf_addr_t word_idx; // address of the word being gathered.

  logic [4:0] bit_cnt;
  logic       accept;
  logic       word_done;

  assign rx_bit_ready = !wr_valid; // hold off while a word waits.
  assign accept       = rx_bit_valid && rx_bit_ready;
  assign word_done    = accept && (bit_cnt == 5'd31) && !tslot_p;

  ////////////////////////////////////////
  // bit count and write handshake.
  ////////////////////////////////////////

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      bit_cnt  <= '0;
      word_idx <= '0;
      wr_valid <= 1'b0;
    end
    else
    begin
      if (wr_valid && wr_ready)
        wr_valid <= 1'b0;
      if (tslot_p)
      begin
        bit_cnt  <= '0; // partial word is dropped.
        word_idx <= '0;
      end
      else if (accept)
      begin
        bit_cnt <= bit_cnt + 5'd1;
        if (word_done)
        begin
          wr_valid <= 1'b1;
          word_idx <= word_idx + 8'd1;
        end
      end
    end
  end

  always_ff @(posedge clk_6M)
  begin
    if (accept)
      sreg <= {rx_bit, sreg[31:1]};
    if (word_done)
    begin
      wr_data <= {rx_bit, sreg[31:1]};
      wr_addr <= word_idx;
    end
  end

endmodule

// File: logic/rx_payload_buffer.sv
`timescale 1ns/1ps

module rx_payload_buffer #(
  parameter int BANK_WORDS = 16
) (
  input  logic                  clk_6M,
  input  logic                  rstz,
  input  logic                  rx_tsco_p,
  input  bb_buf_pkg::chan_t     rx_chan,
  input  bb_buf_pkg::buf_addr_t wr_addr,
  input  bb_buf_pkg::word_t     wr_data,
  input  logic                  wr_valid,
  output logic                  wr_ready,
  input  bb_buf_pkg::host_rd_t  host_rd,
  input  logic                  host_rd_valid,
  output logic                  host_rd_ready,
  output bb_buf_pkg::word_t     rd_data,
  output logic                  rd_data_valid
);

  localparam int AW = (BANK_WORDS > 1) ? $clog2(BANK_WORDS) : 1;

  bb_buf_pkg::word_t acl_ram [BANK_WORDS];
  bb_buf_pkg::word_t sco_ram [2][BANK_WORDS];

  logic          sco_bank; // sco bank being received.
  logic          rd_sco;
  logic          wr_sco;
  logic          rd_en;
  logic          wr_en;
  logic [AW-1:0] rd_idx;
  logic [AW-1:0] wr_idx;

  assign rd_sco = (host_rd.chan == bb_buf_pkg::CHAN_SCO);
  assign wr_sco = (rx_chan == bb_buf_pkg::CHAN_SCO);
  assign rd_idx = host_rd.addr[AW-1:0];
  assign wr_idx = wr_addr[AW-1:0];

  assign host_rd_ready = 1'b1; // response path never stalls.
  assign rd_en         = host_rd_valid && host_rd_ready;

  // host read wins the ram.
  assign wr_ready = !(host_rd_valid && (host_rd.chan == rx_chan));
  assign wr_en    = wr_valid && wr_ready;

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
    begin
      sco_bank      <= 1'b0;
      rd_data_valid <= 1'b0;
    end
    else
    begin
      if (rx_tsco_p)
        sco_bank <= ~sco_bank;
      rd_data_valid <= rd_en;
    end
  end

  ////////////////////////////////////////
  // rams.
  ////////////////////////////////////////

  always_ff @(posedge clk_6M)
  begin
    if (wr_en && !wr_sco)
      acl_ram[wr_idx] <= wr_data;
    if (wr_en && wr_sco)
      sco_ram[sco_bank][wr_idx] <= wr_data;
    if (rd_en)
    begin
      if (rd_sco)
        rd_data <= sco_ram[~sco_bank][rd_idx]; // host reads the idle bank.
      else
        rd_data <= acl_ram[rd_idx];
    end
  end

endmodule

// File: logic/baseband_bufctrl.sv
`timescale 1ns/1ps

module baseband_bufctrl #(
  parameter int BANK_WORDS = 16
) (
  input  logic                    clk_6M,
  input  logic                    rstz,
  input  bb_slot_pkg::slot_ctrl_t slot_ctrl,
  input  logic                    tx_seqn,
  input  logic                    tx_tsco_p,
  input  logic                    rx_tsco_p,
  input  bb_buf_pkg::host_wr_t    host_wr,
  input  logic                    host_wr_valid,
  output logic                    host_wr_ready,
  input  bb_buf_pkg::host_rd_t    host_rd,
  input  logic                    host_rd_valid,
  output logic                    host_rd_ready,
  output bb_buf_pkg::word_t       rd_data,
  output logic                    rd_data_valid,
  output logic                    tx_bit,
  output logic                    tx_bit_valid,
  input  logic                    tx_bit_ready,
  input  logic                    rx_bit,
  input  logic                    rx_bit_valid,
  output logic                    rx_bit_ready
);

  bb_buf_pkg::chan_t     tx_chan;
  bb_buf_pkg::chan_t     rx_chan;
  bb_buf_pkg::buf_addr_t fetch_addr;
  bb_buf_pkg::word_t     fetch_data;
  bb_buf_pkg::buf_addr_t pk_wr_addr;
  bb_buf_pkg::word_t     pk_wr_data;

  logic fetch_valid;
  logic fetch_data_valid;
  logic pk_wr_valid;
  logic pk_wr_ready;

  slot_arbiter slot_arbiter_inst (
    .clk_6M    (clk_6M),
    .rstz      (rstz),
    .slot_ctrl (slot_ctrl),
    .tx_chan   (tx_chan),
    .rx_chan   (rx_chan)
  );

  ////////////////////////////////////////
  // transmit path.
  ////////////////////////////////////////

  tx_payload_buffer #(.BANK_WORDS(BANK_WORDS)) tx_payload_buffer_inst (
    .clk_6M           (clk_6M),
    .rstz             (rstz),
    .tx_seqn          (tx_seqn),
    .tx_tsco_p        (tx_tsco_p),
    .host_wr          (host_wr),
    .host_wr_valid    (host_wr_valid),
    .host_wr_ready    (host_wr_ready),
    .tx_chan          (tx_chan),
    .fetch_addr       (fetch_addr),
    .fetch_valid      (fetch_valid),
    .fetch_data       (fetch_data),
    .fetch_data_valid (fetch_data_valid)
  );

  tx_bit_serializer tx_bit_serializer_inst (
    .clk_6M           (clk_6M),
    .rstz             (rstz),
    .tslot_p          (slot_ctrl.tslot_p),
    .tx_len           (slot_ctrl.tx_len),
    .fetch_addr       (fetch_addr),
    .fetch_valid      (fetch_valid),
    .fetch_data       (fetch_data),
    .fetch_data_valid (fetch_data_valid),
    .tx_bit           (tx_bit),
    .tx_bit_valid     (tx_bit_valid),
    .tx_bit_ready     (tx_bit_ready)
  );

  ////////////////////////////////////////
  // receive path.
  ////////////////////////////////////////

  rx_bit_packer rx_bit_packer_inst (
    .clk_6M       (clk_6M),
    .rstz         (rstz),
    .tslot_p      (slot_ctrl.tslot_p),
    .rx_bit       (rx_bit),
    .rx_bit_valid (rx_bit_valid),
    .rx_bit_ready (rx_bit_ready),
    .wr_addr      (pk_wr_addr),
    .wr_data      (pk_wr_data),
    .wr_valid     (pk_wr_valid),
    .wr_ready     (pk_wr_ready)
  );

  rx_payload_buffer #(.BANK_WORDS(BANK_WORDS)) rx_payload_buffer_inst (
    .clk_6M        (clk_6M),
    .rstz          (rstz),
    .rx_tsco_p     (rx_tsco_p),
    .rx_chan       (rx_chan),
    .wr_addr       (pk_wr_addr),
    .wr_data       (pk_wr_data),
    .wr_valid      (pk_wr_valid),
    .wr_ready      (pk_wr_ready),
    .host_rd       (host_rd),
    .host_rd_valid (host_rd_valid),
    .host_rd_ready (host_rd_ready),
    .rd_data       (rd_data),
    .rd_data_valid (rd_data_valid)
  );

endmodule

// File: sim/bufctrl_assert.sv
`timescale 1ns/1ps

module bufctrl_assert #(
  parameter int BANK_WORDS = 16
) (
  input logic                    clk_6M,
  input logic                    rstz,
  input bb_slot_pkg::slot_ctrl_t slot_ctrl,
  input bb_buf_pkg::host_wr_t    host_wr,
  input logic                    host_wr_valid,
  input logic                    host_wr_ready,
  input bb_buf_pkg::host_rd_t    host_rd,
  input logic                    host_rd_valid,
  input logic                    host_rd_ready,
  input logic                    rd_data_valid,
  input logic                    tx_bit,
  input logic                    tx_bit_valid,
  input logic                    tx_bit_ready
);

  logic slot_seen; // a slot boundary has passed since reset.

  always_ff @(posedge clk_6M or negedge rstz)
  begin
    if (!rstz)
      slot_seen <= 1'b0;
    else if (slot_ctrl.tslot_p)
      slot_seen <= 1'b1;
  end

  ////////////////////////////////////////
  // handshakes.
  ////////////////////////////////////////

  wr_hold: assert property (@(posedge clk_6M) disable iff (!rstz)
    host_wr_valid && !host_wr_ready |=> host_wr_valid && $stable(host_wr))
    else $error("host write request changed while stalled");

  // a new slot may restart the bit stream.
  tx_hold: assert property (@(posedge clk_6M) disable iff (!rstz)
    tx_bit_valid && !tx_bit_ready && !slot_ctrl.tslot_p |=> tx_bit_valid && $stable(tx_bit))
    else $error("tx bit dropped or changed under back-pressure");

  ////////////////////////////////////////
  // addresses and response timing.
  ////////////////////////////////////////

  wr_addr_range: assert property (@(posedge clk_6M) disable iff (!rstz)
    host_wr_valid |-> host_wr.addr < BANK_WORDS)
    else $error("host write address beyond the bank");

  rd_addr_range: assert property (@(posedge clk_6M) disable iff (!rstz)
    host_rd_valid |-> host_rd.addr < BANK_WORDS)
    else $error("host read address beyond the bank");

  rd_resp_follows: assert property (@(posedge clk_6M) disable iff (!rstz)
    host_rd_valid && host_rd_ready |=> rd_data_valid)
    else $error("no read response one cycle after an accepted read");

  rd_resp_caused: assert property (@(posedge clk_6M) disable iff (!rstz)
    rd_data_valid |-> $past(host_rd_valid && host_rd_ready))
    else $error("read response without an accepted read");

  tx_after_slot: assert property (@(posedge clk_6M) disable iff (!rstz)
    tx_bit_valid |-> slot_seen)
    else $error("tx bit valid before any slot boundary");

endmodule

bind baseband_bufctrl bufctrl_assert #(.BANK_WORDS(BANK_WORDS)) bufctrl_assert_inst (
  .clk_6M        (clk_6M),
  .rstz          (rstz),
  .slot_ctrl     (slot_ctrl),
  .host_wr       (host_wr),
  .host_wr_valid (host_wr_valid),
  .host_wr_ready (host_wr_ready),
  .host_rd       (host_rd),
  .host_rd_valid (host_rd_valid),
  .host_rd_ready (host_rd_ready),
  .rd_data_valid (rd_data_valid),
  .tx_bit        (tx_bit),
  .tx_bit_valid  (tx_bit_valid),
  .tx_bit_ready  (tx_bit_ready)
);

// File: sim/tb_baseband_bufctrl.sv
`timescale 1ns/1ps

module tb_baseband_bufctrl;

  localparam int BANK_WORDS = 16;
  localparam int MAX_BITS   = BANK_WORDS * 32;
  localparam int NUM_SLOTS  = 8;
  // up to three cycles per bit under random ready, plus host traffic.
  localparam int WATCHDOG_NS = (NUM_SLOTS * MAX_BITS * 3 + 3000) * 4;

  logic                    clk_6M = 1'b0;
  logic                    rstz;
  bb_slot_pkg::slot_ctrl_t slot_ctrl;
  logic                    tx_seqn;
  logic                    tx_tsco_p;
  logic                    rx_tsco_p;
  bb_buf_pkg::host_wr_t    host_wr;
  logic                    host_wr_valid;
  logic                    host_wr_ready;
  bb_buf_pkg::host_rd_t    host_rd;
  logic                    host_rd_valid;
  logic                    host_rd_ready;
  bb_buf_pkg::word_t       rd_data;
  logic                    rd_data_valid;
  logic                    tx_bit;
  logic                    tx_bit_valid;
  logic                    tx_bit_ready;
  logic                    rx_bit;
  logic                    rx_bit_valid;
  logic                    rx_bit_ready;

  logic [31:0] seed = 32'd45329;

  // reference model of the banks and the slot rule.
  bb_buf_pkg::word_t ref_acl_tx [2][BANK_WORDS];
  bb_buf_pkg::word_t ref_sco_tx [2][BANK_WORDS];
  bb_buf_pkg::word_t ref_acl_rx [BANK_WORDS];
  bb_buf_pkg::word_t ref_sco_rx [2][BANK_WORDS];
  logic              ref_tx_bank; // sco bank being sent.
  logic              ref_rx_bank; // sco bank being filled.
  logic              ref_lmp_cmd;

  baseband_bufctrl #(.BANK_WORDS(BANK_WORDS)) baseband_bufctrl_inst (.*);

  always #2 clk_6M = ~clk_6M;

  ////////////////////////////////////////
  // helpers and compare tasks.
  ////////////////////////////////////////

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic bb_slot_pkg::bit_count_t rand_len();
    logic [31:0] r;
    r = lcg_next();
    return bb_slot_pkg::bit_count_t'(33 + r % 480); // 33 to 512 bits.
  endfunction

  task automatic abort_run();
    $display("=== FAIL ===");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp)
    begin
      $display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_word(string name, bb_buf_pkg::word_t got, bb_buf_pkg::word_t exp);
    if (got !== exp)
    begin
      $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_chan(string name, bb_buf_pkg::chan_t got, bb_buf_pkg::chan_t exp);
    if (got !== exp)
    begin
      $display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic host_write(bb_buf_pkg::chan_t chan, bb_buf_pkg::buf_addr_t addr,
                            bb_buf_pkg::word_t data);
    logic done;
    logic bank;
    bank = (chan == bb_buf_pkg::CHAN_SCO) ? ~ref_tx_bank : ~tx_seqn; // idle bank.
    @(negedge clk_6M);
    host_wr.chan  = chan;
    host_wr.addr  = addr;
    host_wr.data  = data;
    host_wr_valid = 1'b1;
    done = 1'b0;
    while (!done)
    begin
      #1;
      done = host_wr_ready;
      @(negedge clk_6M);
    end
    host_wr_valid = 1'b0;
    if (chan == bb_buf_pkg::CHAN_SCO)
      ref_sco_tx[bank][int'(addr)] = data;
    else
      ref_acl_tx[bank][int'(addr)] = data;
  endtask

  task automatic fill_tx_bank(bb_buf_pkg::chan_t chan);
    for (int i = 0; i < BANK_WORDS; i++)
      host_write(chan, bb_buf_pkg::buf_addr_t'(i), lcg_next());
  endtask

  task automatic read_and_compare(bb_buf_pkg::chan_t chan, bb_buf_pkg::buf_addr_t addr);
    bb_buf_pkg::word_t exp;
    logic              done;
    if (chan == bb_buf_pkg::CHAN_SCO)
      exp = ref_sco_rx[~ref_rx_bank][int'(addr)]; // host sees the idle bank.
    else
      exp = ref_acl_rx[int'(addr)];
    @(negedge clk_6M);
    host_rd.chan  = chan;
    host_rd.addr  = addr;
    host_rd_valid = 1'b1;
    done = 1'b0;
    while (!done)
    begin
      #1;
      done = host_rd_ready;
      @(negedge clk_6M);
    end
    host_rd_valid = 1'b0;
    while (!rd_data_valid)
      @(negedge clk_6M);
    check_word("rd_data", rd_data, exp);
  endtask

  task automatic start_slot(logic tx_res, logic rx_res, bb_slot_pkg::bit_count_t len,
                            output bb_buf_pkg::chan_t tx_exp,
                            output bb_buf_pkg::chan_t rx_exp);
    logic lmp_slot;
    lmp_slot    = ref_lmp_cmd;
    ref_lmp_cmd = 1'b0;
    tx_exp = (tx_res && !lmp_slot) ? bb_buf_pkg::CHAN_SCO : bb_buf_pkg::CHAN_ACL;
    rx_exp = (rx_res && !lmp_slot) ? bb_buf_pkg::CHAN_SCO : bb_buf_pkg::CHAN_ACL;
    @(negedge clk_6M);
    slot_ctrl.tslot_p     = 1'b1;
    slot_ctrl.tx_reserved = tx_res;
    slot_ctrl.rx_reserved = rx_res;
    slot_ctrl.tx_len      = len;
    @(negedge clk_6M);
    slot_ctrl.tslot_p = 1'b0;
  endtask

  task automatic pulse_lmp();
    @(negedge clk_6M);
    slot_ctrl.lmp_cmd_p = 1'b1;
    @(negedge clk_6M);
    slot_ctrl.lmp_cmd_p = 1'b0;
    ref_lmp_cmd = 1'b1;
  endtask

  task automatic swap_tx_sco();
    @(negedge clk_6M);
    tx_tsco_p = 1'b1;
    @(negedge clk_6M);
    tx_tsco_p   = 1'b0;
    ref_tx_bank = ~ref_tx_bank;
  endtask

  ////////////////////////////////////////
  // slot runners.
  ////////////////////////////////////////

  task automatic tx_slot(logic reserved, bb_slot_pkg::bit_count_t len, logic random_ready);
    bb_buf_pkg::chan_t exp_chan;
    bb_buf_pkg::chan_t rx_exp;
    bb_buf_pkg::chan_t seen_chan;
    bb_buf_pkg::word_t exp_word;
    bb_buf_pkg::word_t first;
    logic              got [$];
    logic [31:0]       r;
    int                n;
    start_slot(reserved, 1'b0, len, exp_chan, rx_exp);
    n = 0;
    while (n < int'(len))
    begin
      @(negedge clk_6M);
      r = lcg_next();
      tx_bit_ready = random_ready ? r[20] : 1'b1;
      if (tx_bit_valid && tx_bit_ready)
      begin
        got.push_back(tx_bit); // sent on the coming edge.
        n++;
      end
    end
    for (n = 0; n < 32; n++)
      first[n] = got[n];
    seen_chan = (first == ref_sco_tx[ref_tx_bank][0]) ? bb_buf_pkg::CHAN_SCO
                                                       : bb_buf_pkg::CHAN_ACL;
    check_chan("tx_chan", seen_chan, exp_chan);
    for (n = 0; n < int'(len); n++)
    begin
      if (exp_chan == bb_buf_pkg::CHAN_SCO)
        exp_word = ref_sco_tx[ref_tx_bank][n / 32];
      else
        exp_word = ref_acl_tx[tx_seqn][n / 32];
      check_bit("tx_bit", got[n], exp_word[n % 32]);
    end
    repeat (8)
    begin
      @(negedge clk_6M);
      check_bit("tx_bit_valid", tx_bit_valid, 1'b0);
    end
    tx_bit_ready = 1'b0;
  endtask

  task automatic rx_slot(logic reserved, int nbits);
    bb_buf_pkg::chan_t tx_exp;
    bb_buf_pkg::chan_t chan;
    bb_buf_pkg::word_t w;
    logic [31:0]       r;
    int                i;
    start_slot(1'b0, reserved, '0, tx_exp, chan);
    w = '0;
    for (i = 0; i < nbits; i++)
    begin
      r = lcg_next();
      @(negedge clk_6M);
      rx_bit       = r[16];
      rx_bit_valid = 1'b1;
      while (!rx_bit_ready)
        @(negedge clk_6M);
      w[i % 32] = r[16]; // lsb first.
      if (i % 32 == 31)
      begin
        if (chan == bb_buf_pkg::CHAN_SCO)
          ref_sco_rx[ref_rx_bank][i / 32] = w;
        else
          ref_acl_rx[i / 32] = w;
      end
    end
    @(negedge clk_6M);
    rx_bit_valid = 1'b0;
    while (!rx_bit_ready)
      @(negedge clk_6M); // last word still going into the ram.
  endtask

  ////////////////////////////////////////
  // directed tests.
  ////////////////////////////////////////

  task automatic acl_banking();
    fill_tx_bank(bb_buf_pkg::CHAN_ACL);
    @(negedge clk_6M);
    tx_seqn = ~tx_seqn;
    tx_slot(1'b0, rand_len(), 1'b0);
  endtask

  task automatic lmp_override();
    fill_tx_bank(bb_buf_pkg::CHAN_SCO);
    swap_tx_sco();
    pulse_lmp();
    tx_slot(1'b1, rand_len(), 1'b0); // lmp takes the reserved slot.
    tx_slot(1'b1, rand_len(), 1'b0);
  endtask

  task automatic sco_bank_swap();
    fill_tx_bank(bb_buf_pkg::CHAN_SCO);
    swap_tx_sco();
    tx_slot(1'b1, rand_len(), 1'b0);
  endtask

  task automatic tx_back_pressure();
    tx_slot(1'b0, rand_len(), 1'b1);
  endtask

  task automatic rx_packing();
    rx_slot(1'b0, 4 * 32);
    rx_slot(1'b0, 3 * 32 + 10); // word 3 keeps the older data.
    rx_slot(1'b1, 2 * 32 + 5);
    @(negedge clk_6M);
    rx_tsco_p = 1'b1;
    @(negedge clk_6M);
    rx_tsco_p   = 1'b0;
    ref_rx_bank = ~ref_rx_bank;
    for (int i = 0; i < 4; i++)
      read_and_compare(bb_buf_pkg::CHAN_ACL, bb_buf_pkg::buf_addr_t'(i));
    for (int i = 0; i < 2; i++)
      read_and_compare(bb_buf_pkg::CHAN_SCO, bb_buf_pkg::buf_addr_t'(i));
  endtask

  initial
  begin
    #(WATCHDOG_NS);
    $display("timeout, tests still running after %0d ns", WATCHDOG_NS);
    $display("=== FAIL ===");
    $fatal(1, "watchdog expired");
  end

  initial
  begin
    rstz          = 1'b0;
    slot_ctrl     = '0;
    tx_seqn       = 1'b0;
    tx_tsco_p     = 1'b0;
    rx_tsco_p     = 1'b0;
    host_wr       = '0;
    host_wr_valid = 1'b0;
    host_rd       = '0;
    host_rd_valid = 1'b0;
    tx_bit_ready  = 1'b0;
    rx_bit        = 1'b0;
    rx_bit_valid  = 1'b0;
    ref_acl_tx    = '{default: '0};
    ref_sco_tx    = '{default: '0};
    ref_acl_rx    = '{default: '0};
    ref_sco_rx    = '{default: '0};
    ref_tx_bank   = 1'b0;
    ref_rx_bank   = 1'b0;
    ref_lmp_cmd   = 1'b0;
    repeat (4) @(posedge clk_6M);
    @(negedge clk_6M);
    rstz = 1'b1;
    acl_banking();
    lmp_override();
    sco_bank_swap();
    tx_back_pressure();
    rx_packing();
    $display("=== PASS ===");
    $finish;
  end

endmodule

// File: project.f
logic/bb_buf_pkg.sv
logic/bb_slot_pkg.sv
logic/slot_arbiter.sv
logic/tx_payload_buffer.sv
logic/tx_bit_serializer.sv
logic/rx_bit_packer.sv
logic/rx_payload_buffer.sv
logic/baseband_bufctrl.sv
sim/bufctrl_assert.sv
sim/tb_baseband_bufctrl.sv

// File: run.sh
#!/bin/sh
# build with verilator, run, and look for the pass line in the output.
verilator --binary --timing --assert -Wno-fatal -f project.f \
  --top-module tb_baseband_bufctrl -Mdir obj_dir -o tb_sim || exit 1
out=$(./obj_dir/tb_sim)
echo "$out"
echo "$out" | grep -qx '=== PASS ===' && echo "run.sh: simulation passed" || \
  { echo "run.sh: simulation failed"; exit 1; }
